//--- daq_config.svh
`ifndef DAQ_CONFIG_SVH
`define DAQ_CONFIG_SVH

// Local bus address width
`define DAQ_ABUS_WIDTH 16

// Register block base addresses
`define DAQ_SYSTEM_BASE 16'h0300
`define PULSE_RST_BASE 16'h0400
`define BOARD_CTRL_BASE 16'h0500

// Every block decodes one 256 byte window
`define DAQ_BLOCK_SPAN 256

// Firmware identification
`define DAQ_MODULE_VERSION 8'd1
`define DAQ_VERSION_MAJOR 8'd1
`define DAQ_VERSION_MINOR 8'd2

// Board ID of the simulation target
`define DAQ_BOARD_ID 8'd0

// Readout arbiter
`define ARB_N_SOURCES 4
`define ARB_DATA_WIDTH 32

`endif

//--- daq_pkg.sv
`include "daq_config.svh"

package daq_pkg;

    // Local bus request as seen at the core boundary
    typedef struct packed {
        logic                       rd;
        logic                       wr;
        logic [`DAQ_ABUS_WIDTH-1:0] addr;
        logic [7:0]                 data;
    } bus_req_t;

    // Request after decode with a block-relative offset
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [7:0] offset;
        logic [7:0] data;
    } blk_req_t;

    // One FWFT FIFO source in front of the arbiter
    typedef struct packed {
        logic                       not_empty;
        logic                       hold;
        logic [`ARB_DATA_WIDTH-1:0] data;
    } arb_src_t;

    // Board-control word with sense in the low nibble
    typedef struct packed {
        logic       ref_sel;
        logic [7:0] lemo_mux;
        logic [2:0] ntc_mux;
        logic [3:0] sense;
    } board_ctrl_fields_t;

    // Same word seen by the bus as two bytes
    typedef union packed {
        board_ctrl_fields_t  f;
        logic [1:0][7:0]     bytes;
    } board_ctrl_u;

endpackage

//--- bus_fabric.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module bus_fabric (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::bus_req_t i_bus,
    input  logic [7:0]        i_sys_rdata,
    input  logic [7:0]        i_ctrl_rdata,
    input  logic [7:0]        i_pulse_rdata,
    output daq_pkg::blk_req_t o_sys_req,
    output daq_pkg::blk_req_t o_ctrl_req,
    output daq_pkg::blk_req_t o_pulse_req,
    output logic [7:0]        o_bus_data
);

    localparam logic [1:0] SEL_NONE  = 2'd0;
    localparam logic [1:0] SEL_SYS   = 2'd1;
    localparam logic [1:0] SEL_CTRL  = 2'd2;
    localparam logic [1:0] SEL_PULSE = 2'd3;

    logic       sys_hit;
    logic       ctrl_hit;
    logic       pulse_hit;
    logic [1:0] rd_sel_q;

    function automatic logic in_block(input logic [`DAQ_ABUS_WIDTH-1:0] addr,
                                      input int unsigned base);
        return (addr >= base) && (addr < base + `DAQ_BLOCK_SPAN);
    endfunction

    assign sys_hit   = in_block(i_bus.addr, `DAQ_SYSTEM_BASE);
    assign ctrl_hit  = in_block(i_bus.addr, `BOARD_CTRL_BASE);
    assign pulse_hit = in_block(i_bus.addr, `PULSE_RST_BASE);

    // Strobes only reach the addressed block
    assign o_sys_req   = '{rd: i_bus.rd && sys_hit, wr: i_bus.wr && sys_hit,
                           offset: i_bus.addr[7:0], data: i_bus.data};
    assign o_ctrl_req  = '{rd: i_bus.rd && ctrl_hit, wr: i_bus.wr && ctrl_hit,
                           offset: i_bus.addr[7:0], data: i_bus.data};
    assign o_pulse_req = '{rd: i_bus.rd && pulse_hit, wr: i_bus.wr && pulse_hit,
                           offset: i_bus.addr[7:0], data: i_bus.data};

    // Remember which block was read since blocks answer one cycle later
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_sel_q <= SEL_NONE;
        end else if (i_bus.rd) begin
            if (sys_hit) begin
                rd_sel_q <= SEL_SYS;
            end else if (ctrl_hit) begin
                rd_sel_q <= SEL_CTRL;
            end else if (pulse_hit) begin
                rd_sel_q <= SEL_PULSE;
            end else begin
                rd_sel_q <= SEL_NONE;
            end
        end
    end

    always_comb begin
        case (rd_sel_q)
            SEL_SYS:   o_bus_data = i_sys_rdata;
            SEL_CTRL:  o_bus_data = i_ctrl_rdata;
            SEL_PULSE: o_bus_data = i_pulse_rdata;
            default:   o_bus_data = 8'h00;
        endcase
    end

    // Bus master never issues read and write together
    a_no_rd_wr: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !(i_bus.rd && i_bus.wr));

endmodule

//--- daq_system_regs.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module daq_system_regs (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::blk_req_t i_req,
    output logic [7:0]        o_rdata
);

    // Set by software once the clock synthesizer is programmed
    logic configured_q;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            configured_q <= 1'b0;
        end else if (i_req.wr && (i_req.offset == 8'd5)) begin
            configured_q <= i_req.data[0];
        end
    end

    // Readback byte
    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            case (i_req.offset)
                8'd0:    o_rdata <= `DAQ_MODULE_VERSION;
                8'd1:    o_rdata <= `DAQ_VERSION_MINOR;
                8'd2:    o_rdata <= `DAQ_VERSION_MAJOR;
                8'd3:    o_rdata <= `DAQ_BOARD_ID;
                8'd4:    o_rdata <= {7'b0, configured_q};
                default: o_rdata <= 8'h00;
            endcase
        end
    end

endmodule

//--- board_control_regs.sv
`timescale 1ns/100ps

module board_control_regs (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::blk_req_t i_req,
    input  logic [3:0]        i_gpio_sense,
    output logic [7:0]        o_rdata,
    output logic              o_mgt_ref_sel,
    output logic [7:0]        o_lemo_mux,
    output logic [2:0]        o_ntc_mux
);
    import daq_pkg::*;

    board_ctrl_u ctrl_q;

    // Bus writes land byte-wise
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ctrl_q <= '0;
        end else if (i_req.wr && (i_req.offset[7:1] == 7'd0)) begin
            ctrl_q.bytes[i_req.offset[0]] <= i_req.data;
        end
        // Sense inputs win over any write to the low nibble
        ctrl_q.f.sense <= i_gpio_sense;
    end

    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            if (i_req.offset[7:1] == 7'd0) begin
                o_rdata <= ctrl_q.bytes[i_req.offset[0]];
            end else begin
                o_rdata <= 8'h00;
            end
        end
    end

    // A cleared ref_sel selects the on-board reference clock
    assign o_mgt_ref_sel = ~ctrl_q.f.ref_sel;
    assign o_lemo_mux    = ctrl_q.f.lemo_mux;
    assign o_ntc_mux     = ctrl_q.f.ntc_mux;

endmodule

//--- reset_pulser.sv
`timescale 1ns/100ps

module reset_pulser (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::blk_req_t i_req,
    output logic [7:0]        o_rdata,
    output logic              o_resetb_ext
);

    logic [7:0] width_q;
    logic [7:0] cnt_q;
    logic       busy;
    logic       start;

    assign busy  = (cnt_q != 8'd0);
    assign start = i_req.wr && (i_req.offset == 8'd0) && !busy;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            width_q <= 8'd0;
        end else if (i_req.wr && (i_req.offset == 8'd3)) begin
            width_q <= i_req.data;
        end
    end

    // Counter holds the remaining low cycles
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            cnt_q        <= 8'd0;
            o_resetb_ext <= 1'b1;
        end else if (start) begin
            cnt_q        <= width_q;
            o_resetb_ext <= (width_q == 8'd0);
        end else if (busy) begin
            cnt_q        <= cnt_q - 8'd1;
            o_resetb_ext <= (cnt_q == 8'd1);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            case (i_req.offset)
                8'd1:    o_rdata <= {7'b0, !busy};
                8'd3:    o_rdata <= width_q;
                default: o_rdata <= 8'h00;
            endcase
        end
    end

    a_low_only_when_counting: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !o_resetb_ext |-> busy);

endmodule

//--- rr_readout_arbiter.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module rr_readout_arbiter (
    input  logic                                  BUS_CLK,
    input  logic                                  BUS_RST,
    input  daq_pkg::arb_src_t [`ARB_N_SOURCES-1:0] i_src,
    input  logic                                  i_arb_ready,
    output logic [`ARB_N_SOURCES-1:0]             o_src_read,
    output logic                                  o_arb_write,
    output logic [`ARB_DATA_WIDTH-1:0]            o_arb_data
);

    localparam int N_SRC = `ARB_N_SOURCES;
    localparam int PTR_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

    logic [PTR_W-1:0] last_q;
    logic             granted_q;
    logic [N_SRC-1:0] not_empty;
    logic             grant_vld;
    logic [PTR_W-1:0] grant_idx;

    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            not_empty[i] = i_src[i].not_empty;
        end
    end

    // Hold keeps the last winner, else search downwards from it with wrap
    always_comb begin
        logic [PTR_W-1:0] cand;
        grant_vld = 1'b0;
        grant_idx = last_q;
        cand      = last_q;
        if (i_arb_ready) begin
            if (granted_q && i_src[last_q].hold && not_empty[last_q]) begin
                grant_vld = 1'b1;
            end else begin
                for (int k = 1; k <= N_SRC; k++) begin
                    cand = PTR_W'((int'(last_q) + N_SRC - k) % N_SRC);
                    if (!grant_vld && not_empty[cand]) begin
                        grant_vld = 1'b1;
                        grant_idx = cand;
                    end
                end
            end
        end
    end

    // Pop strobe to the FWFT source in the grant cycle
    always_comb begin
        o_src_read = '0;
        if (grant_vld) begin
            o_src_read[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last_q      <= '0;
            granted_q   <= 1'b0;
            o_arb_write <= 1'b0;
        end else begin
            o_arb_write <= grant_vld;
            if (grant_vld) begin
                last_q    <= grant_idx;
                granted_q <= 1'b1;
            end
        end
    end

    // Head word captured as it is popped
    always_ff @(posedge BUS_CLK) begin
        if (grant_vld) begin
            o_arb_data <= i_src[grant_idx].data;
        end
    end

    a_pop_onehot: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        $onehot0(o_src_read));

    a_pop_not_empty: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (o_src_read & ~not_empty) == '0);

    a_no_pop_unready: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !i_arb_ready |-> (o_src_read == '0));

endmodule

//--- daq_core.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module daq_core (
    input  logic                                  BUS_CLK,
    input  logic                                  BUS_RST,
    input  daq_pkg::bus_req_t                     i_bus,
    output logic [7:0]                            o_bus_data,
    input  logic [3:0]                            i_gpio_sense,
    output logic                                  o_mgt_ref_sel,
    output logic [7:0]                            o_lemo_mux,
    output logic [2:0]                            o_ntc_mux,
    output logic                                  o_resetb_ext,
    input  daq_pkg::arb_src_t [`ARB_N_SOURCES-1:0] i_src,
    output logic [`ARB_N_SOURCES-1:0]             o_src_read,
    input  logic                                  i_arb_ready,
    output logic                                  o_arb_write,
    output logic [`ARB_DATA_WIDTH-1:0]            o_arb_data
);
    import daq_pkg::*;

    blk_req_t   sys_req;
    blk_req_t   ctrl_req;
    blk_req_t   pulse_req;
    logic [7:0] sys_rdata;
    logic [7:0] ctrl_rdata;
    logic [7:0] pulse_rdata;

    bus_fabric fabric_i (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_bus         (i_bus),
        .i_sys_rdata   (sys_rdata),
        .i_ctrl_rdata  (ctrl_rdata),
        .i_pulse_rdata (pulse_rdata),
        .o_sys_req     (sys_req),
        .o_ctrl_req    (ctrl_req),
        .o_pulse_req   (pulse_req),
        .o_bus_data    (o_bus_data)
    );

    daq_system_regs system_i (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .i_req   (sys_req),
        .o_rdata (sys_rdata)
    );

    board_control_regs board_ctrl_i (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_req         (ctrl_req),
        .i_gpio_sense  (i_gpio_sense),
        .o_rdata       (ctrl_rdata),
        .o_mgt_ref_sel (o_mgt_ref_sel),
        .o_lemo_mux    (o_lemo_mux),
        .o_ntc_mux     (o_ntc_mux)
    );

    // Chip external reset
    reset_pulser pulse_rst_i (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_req        (pulse_req),
        .o_rdata      (pulse_rdata),
        .o_resetb_ext (o_resetb_ext)
    );

    // Index 3 RX, 2 TLU, 1 LVDS TDC, 0 CMOS TDC
    rr_readout_arbiter arbiter_i (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_src       (i_src),
        .i_arb_ready (i_arb_ready),
        .o_src_read  (o_src_read),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

endmodule

//--- daq_checker.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module daq_checker (
    input logic                                  BUS_CLK,
    input logic                                  BUS_RST,
    input daq_pkg::bus_req_t                     i_bus,
    input logic [7:0]                            i_bus_data,
    input logic [3:0]                            i_gpio_sense,
    input logic                                  i_mgt_ref_sel,
    input logic [7:0]                            i_lemo_mux,
    input logic [2:0]                            i_ntc_mux,
    input logic                                  i_resetb_ext,
    input daq_pkg::arb_src_t [`ARB_N_SOURCES-1:0] i_src,
    input logic [`ARB_N_SOURCES-1:0]             i_src_read,
    input logic                                  i_arb_ready,
    input logic                                  i_arb_write,
    input logic [`ARB_DATA_WIDTH-1:0]            i_arb_data
);
    import daq_pkg::*;

    localparam int N_SRC = `ARB_N_SOURCES;

    string test_name = "startup";
    int    test_checks;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    check_count;
    int    error_count;

    // Expected register state
    logic        configured;
    logic [15:0] ctrl_word;
    logic [3:0]  sense_q;
    logic [7:0]  pulse_width;
    int          pulse_left;
    logic        rd_pending;
    logic [7:0]  rd_expect;

    // Expected arbiter state
    int                         last_src;
    bit                         have_last;
    logic                       wr_expect;
    logic [`ARB_DATA_WIDTH-1:0] data_expect;
    int                         next_seq [N_SRC];
    int                         delivered [N_SRC];

    // Blocks sit on 256 byte aligned windows
    function automatic bit hits(input logic [15:0] addr, input logic [15:0] base);
        return addr[15:8] == base[15:8];
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] addr);
        if (hits(addr, `DAQ_SYSTEM_BASE)) begin
            case (addr[7:0])
                8'd0:    return `DAQ_MODULE_VERSION;
                8'd1:    return `DAQ_VERSION_MINOR;
                8'd2:    return `DAQ_VERSION_MAJOR;
                8'd3:    return `DAQ_BOARD_ID;
                8'd4:    return {7'd0, configured};
                default: return 8'h00;
            endcase
        end else if (hits(addr, `BOARD_CTRL_BASE)) begin
            case (addr[7:0])
                8'd0:    return {ctrl_word[7:4], sense_q};
                8'd1:    return ctrl_word[15:8];
                default: return 8'h00;
            endcase
        end else if (hits(addr, `PULSE_RST_BASE)) begin
            case (addr[7:0])
                8'd1:    return {7'd0, pulse_left == 0};
                8'd3:    return pulse_width;
                default: return 8'h00;
            endcase
        end
        return 8'h00;
    endfunction

    // Hold keeps the last winner, else next not-empty source downwards
    function automatic int ref_grant(input logic ready, input arb_src_t [N_SRC-1:0] src,
                                     input int last, input bit valid_last);
        int idx;
        if (!ready) return -1;
        if (valid_last && src[last].hold && src[last].not_empty) return last;
        for (int k = 1; k <= N_SRC; k++) begin
            idx = (last + N_SRC - k) % N_SRC;
            if (src[idx].not_empty) return idx;
        end
        return -1;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic flag_problem(input string what);
        $display("Problem in test %s: %s", test_name, what);
        error_count++;
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
        for (int s = 0; s < N_SRC; s++) begin
            next_seq[s]  = 0;
            delivered[s] = 0;
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed after %0d checks", test_name, test_checks);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_delivered(input int s, input int count);
        check_value($sformatf("word count of source %0d", s), count, delivered[s]);
    endtask

    task automatic print_summary();
        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
    endtask

    task automatic apply_write(input logic [15:0] addr, input logic [7:0] data,
                               input bit busy);
        if (hits(addr, `DAQ_SYSTEM_BASE) && addr[7:0] == 8'd5) configured = data[0];
        if (hits(addr, `BOARD_CTRL_BASE) && addr[7:0] == 8'd0) ctrl_word[7:0] = data;
        if (hits(addr, `BOARD_CTRL_BASE) && addr[7:0] == 8'd1) ctrl_word[15:8] = data;
        if (hits(addr, `PULSE_RST_BASE) && addr[7:0] == 8'd3) pulse_width = data;
        // A start while busy is dropped
        if (hits(addr, `PULSE_RST_BASE) && addr[7:0] == 8'd0 && !busy) begin
            pulse_left = pulse_width;
        end
    endtask

    task automatic track_word(input logic [31:0] word);
        int s;
        s = int'(word[31:28]);
        if (s >= N_SRC) begin
            flag_problem("arbiter emitted a word with an unknown source tag");
        end else begin
            check_value($sformatf("sequence of source %0d", s), next_seq[s], word[27:0]);
            next_seq[s]++;
            delivered[s]++;
        end
    endtask

    // Sees the cycle that just ended, then advances the expected state
    always @(posedge BUS_CLK) begin : compare
        int               grant;
        bit               pulse_busy;
        logic [N_SRC-1:0] pop_expect;
        if (BUS_RST) begin
            configured  = 1'b0;
            ctrl_word   = 16'h0000;
            pulse_width = 8'h00;
            pulse_left  = 0;
            rd_pending  = 1'b0;
            wr_expect   = 1'b0;
            last_src    = 0;
            have_last   = 1'b0;
        end else begin
            if (rd_pending) check_value("bus read data", rd_expect, i_bus_data);
            check_value("o_arb_write", wr_expect, i_arb_write);
            if (wr_expect && i_arb_write) begin
                check_value("o_arb_data", data_expect, i_arb_data);
                track_word(i_arb_data);
            end
            check_value("o_mgt_ref_sel", !ctrl_word[15], i_mgt_ref_sel);
            check_value("o_lemo_mux", ctrl_word[14:7], i_lemo_mux);
            check_value("o_ntc_mux", ctrl_word[6:4], i_ntc_mux);
            check_value("o_resetb_ext", pulse_left == 0, i_resetb_ext);

            rd_pending = i_bus.rd;
            if (i_bus.rd) rd_expect = ref_read(i_bus.addr);
            pulse_busy = (pulse_left != 0);
            if (pulse_busy) pulse_left--;
            if (i_bus.wr) apply_write(i_bus.addr, i_bus.data, pulse_busy);

            grant      = ref_grant(i_arb_ready, i_src, last_src, have_last);
            pop_expect = '0;
            if (grant >= 0) pop_expect[grant] = 1'b1;
            check_value("o_src_read", pop_expect, i_src_read);
            wr_expect = (grant >= 0);
            if (grant >= 0) begin
                data_expect = i_src[grant].data;
                last_src    = grant;
                have_last   = 1'b1;
            end
        end
        sense_q = i_gpio_sense;
    end

endmodule

//--- tb_daq_core.sv
`timescale 1ns/100ps
`include "daq_config.svh"

module tb_daq_core;
    import daq_pkg::*;

    localparam int N_SRC       = `ARB_N_SOURCES;
    localparam int FIFO_DEPTH  = 64;
    localparam int DRAIN_LIMIT = 2000;
    localparam int IDLE_POLLS  = 40;

    logic                       BUS_CLK;
    logic                       BUS_RST;
    bus_req_t                   i_bus;
    logic [7:0]                 o_bus_data;
    logic [3:0]                 i_gpio_sense;
    logic                       o_mgt_ref_sel;
    logic [7:0]                 o_lemo_mux;
    logic [2:0]                 o_ntc_mux;
    logic                       o_resetb_ext;
    arb_src_t [N_SRC-1:0]       i_src;
    logic [N_SRC-1:0]           o_src_read;
    logic                       i_arb_ready;
    logic                       o_arb_write;
    logic [`ARB_DATA_WIDTH-1:0] o_arb_data;
    logic [N_SRC-1:0]           hold_en;
    bit                         timed_out;
    int unsigned                seed_draw;

    // FWFT source models with a word store and read and write counts per source
    logic [`ARB_DATA_WIDTH-1:0] fifo_mem [N_SRC][FIFO_DEPTH];
    int                         fifo_rd [N_SRC];
    int                         fifo_wr [N_SRC];

    daq_core dut_i (.*);

    daq_checker chk_i (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_bus         (i_bus),
        .i_bus_data    (o_bus_data),
        .i_gpio_sense  (i_gpio_sense),
        .i_mgt_ref_sel (o_mgt_ref_sel),
        .i_lemo_mux    (o_lemo_mux),
        .i_ntc_mux     (o_ntc_mux),
        .i_resetb_ext  (o_resetb_ext),
        .i_src         (i_src),
        .i_src_read    (o_src_read),
        .i_arb_ready   (i_arb_ready),
        .i_arb_write   (o_arb_write),
        .i_arb_data    (o_arb_data)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    // Pop on the arbiter strobe, then present the new head word
    always @(posedge BUS_CLK) begin
        for (int s = 0; s < N_SRC; s++) begin
            if (o_src_read[s]) fifo_rd[s] = fifo_rd[s] + 1;
            i_src[s] <= '{not_empty: (fifo_rd[s] != fifo_wr[s]), hold: hold_en[s],
                          data: fifo_mem[s][fifo_rd[s] % FIFO_DEPTH]};
        end
    end

    function automatic int words_pending();
        int total;
        total = 0;
        for (int s = 0; s < N_SRC; s++) total += fifo_wr[s] - fifo_rd[s];
        return total;
    endfunction

    task automatic report_timeout(input string what);
        chk_i.flag_problem($sformatf("timeout, %s", what));
        timed_out = 1'b1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        i_bus <= '{rd: 1'b0, wr: 1'b1, addr: addr, data: data};
        @(posedge BUS_CLK);
        i_bus <= '0;
    endtask

    // Read byte is valid in the cycle after the strobe
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        i_bus <= '{rd: 1'b1, wr: 1'b0, addr: addr, data: 8'h00};
        @(posedge BUS_CLK);
        i_bus <= '0;
        @(posedge BUS_CLK);
        data = o_bus_data;
    endtask

    task automatic wait_pulser_idle();
        logic [7:0] rd;
        int         polls;
        rd    = 8'h00;
        polls = 0;
        while (rd[0] !== 1'b1 && polls < IDLE_POLLS) begin
            bus_read(`PULSE_RST_BASE + 16'd1, rd);
            polls++;
        end
        if (rd[0] !== 1'b1) report_timeout("reset pulser never returned to idle");
    endtask

    task automatic test_system_regs();
        logic [7:0] rd;
        chk_i.begin_test("system_regs");
        for (int a = 0; a <= 4; a++) bus_read(`DAQ_SYSTEM_BASE + 16'(a), rd);
        bus_write(`DAQ_SYSTEM_BASE + 16'd5, 8'h01);
        bus_read(`DAQ_SYSTEM_BASE + 16'd4, rd);
        // Unmapped window answers zero
        bus_read(16'h0700, rd);
        chk_i.end_test();
    endtask

    task automatic test_board_control();
        logic [7:0]  rd;
        logic [15:0] word;
        chk_i.begin_test("board_control");
        for (int i = 0; i < 8; i++) begin
            word = 16'($urandom);
            @(posedge BUS_CLK);
            i_gpio_sense <= 4'($urandom);
            bus_write(`BOARD_CTRL_BASE, word[7:0]);
            bus_write(`BOARD_CTRL_BASE + 16'd1, word[15:8]);
            bus_read(`BOARD_CTRL_BASE, rd);
            bus_read(`BOARD_CTRL_BASE + 16'd1, rd);
        end
        chk_i.end_test();
    endtask

    task automatic test_reset_pulser();
        logic [7:0] rd;
        int         width;
        chk_i.begin_test("reset_pulser");
        for (int i = 0; i < 4 && !timed_out; i++) begin
            width = 1 + ($urandom % 20);
            bus_write(`PULSE_RST_BASE + 16'd3, 8'(width));
            bus_read(`PULSE_RST_BASE + 16'd3, rd);
            bus_write(`PULSE_RST_BASE, 8'($urandom));
            // Lands while busy for most widths
            bus_write(`PULSE_RST_BASE, 8'h00);
            wait_pulser_idle();
        end
        if (!timed_out) begin
            bus_write(`PULSE_RST_BASE + 16'd3, 8'h00);
            bus_write(`PULSE_RST_BASE, 8'h00);
            wait_pulser_idle();
        end
        chk_i.end_test();
    endtask

    task automatic run_arbiter(input string name, input logic [N_SRC-1:0] hold_mask,
                               input bit random_ready);
        int loaded [N_SRC];
        int cycles;
        chk_i.begin_test(name);
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b0;
        hold_en     <= hold_mask;
        for (int s = 0; s < N_SRC; s++) begin
            loaded[s] = $urandom % 13;
            if (hold_mask[s] && loaded[s] < 4) loaded[s] = 4;
            for (int n = 0; n < loaded[s]; n++) begin
                fifo_mem[s][fifo_wr[s] % FIFO_DEPTH] = {4'(s), 28'(n)};
                fifo_wr[s]++;
            end
        end
        cycles = 0;
        while (words_pending() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge BUS_CLK);
            i_arb_ready <= random_ready ? 1'($urandom) : 1'b1;
            cycles++;
        end
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b0;
        hold_en     <= '0;
        if (words_pending() != 0) begin
            report_timeout("arbiter did not drain the FIFO sources");
        end else begin
            // Last word leaves one cycle after its pop
            repeat (2) @(posedge BUS_CLK);
            for (int s = 0; s < N_SRC; s++) chk_i.check_delivered(s, loaded[s]);
        end
        chk_i.end_test();
    endtask

    initial begin
        seed_draw    = $urandom(45151);
        BUS_RST      = 1'b1;
        i_bus        = '0;
        i_gpio_sense = 4'h0;
        i_src        = '0;
        i_arb_ready  = 1'b0;
        hold_en      = '0;
        timed_out    = 1'b0;
        repeat (5) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;
        test_system_regs();
        test_board_control();
        test_reset_pulser();
        if (!timed_out) run_arbiter("arbiter_round_robin", 4'b0000, 1'b0);
        if (!timed_out) run_arbiter("arbiter_hold", 4'b0100, 1'b0);
        if (!timed_out) run_arbiter("arbiter_backpressure", 4'b0000, 1'b1);
        repeat (2) @(posedge BUS_CLK);
        chk_i.print_summary();
        if (timed_out || chk_i.error_count != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
daq_pkg.sv
bus_fabric.sv
daq_system_regs.sv
board_control_regs.sv
reset_pulser.sv
rr_readout_arbiter.sv
daq_core.sv
daq_checker.sv
tb_daq_core.sv

//--- Bender.yml
package:
  name: daq_core

sources:
  - include_dirs:
      - .
    files:
      - daq_pkg.sv
      - bus_fabric.sv
      - daq_system_regs.sv
      - board_control_regs.sv
      - reset_pulser.sv
      - rr_readout_arbiter.sv
      - daq_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - daq_checker.sv
      - tb_daq_core.sv
